// ==== Makefile ====
# Verilator build and run of the multiply/divide testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= imuldiv_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and look for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$($(BUILD_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(BUILD_DIR)

// ==== rtl/imuldiv_div_iterative.sv ====
/*
 * iterative signed restoring divider, one quotient bit per cycle;
 * returns quotient and remainder together in one 64-bit response word
 */

`timescale 1ns/1ps
`default_nettype none

`include "imuldiv_settings.svh"

module imuldiv_div_iterative import imuldiv_pkg::*; (
  input logic          clk,
  input logic          reset,
  imuldiv_unit_if.unit port
);

  localparam int cnt_w = $clog2(`IMULDIV_STEPS + 1);

  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_calc = 2'd1;
  localparam logic [1:0] st_done = 2'd2;

  // --------------------------------------------------------------------------
  // control
  // --------------------------------------------------------------------------

  logic [1:0]       state;
  logic [cnt_w-1:0] count;
  logic             load_en;
  logic             step_en;
  logic             sign_en;

  assign load_en = (state == st_idle) && port.req_val;
  assign step_en = (state == st_calc) && (count != cnt_w'(`IMULDIV_STEPS));
  assign sign_en = (state == st_calc) && (count == cnt_w'(`IMULDIV_STEPS));

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      count <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (load_en) begin
            state <= st_calc;
            count <= '0;
          end
        end
        st_calc: begin
          if (sign_en) begin
            state <= st_done;
          end else begin
            count <= count + 1'b1;
          end
        end
        st_done: begin
          if (port.resp_rdy) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  assign port.req_rdy  = (state == st_idle);
  assign port.resp_val = (state == st_done);

  // --------------------------------------------------------------------------
  // datapath
  // --------------------------------------------------------------------------

  logic                       sign_a;
  logic                       sign_b;
  logic [`IMULDIV_XLEN-1:0]   mag_a;
  logic [`IMULDIV_XLEN-1:0]   mag_b;
  logic [`IMULDIV_XLEN-1:0]   dvs;
  // partial remainder in the upper half, dividend bits then quotient below
  logic [2*`IMULDIV_XLEN-1:0] rq;
  logic [2*`IMULDIV_XLEN-1:0] shifted;
  logic [`IMULDIV_XLEN:0]     diff;
  logic                       trial_ok;
  logic                       q_neg;
  logic                       r_neg;
  logic                       dbz;
  logic [`IMULDIV_XLEN-1:0]   rem_fix;
  logic [`IMULDIV_XLEN-1:0]   quot_fix;
  muldiv_result_u             result;

  assign sign_a = port.req_a[`IMULDIV_XLEN-1];
  assign sign_b = port.req_b[`IMULDIV_XLEN-1];
  assign mag_a  = sign_a ? (~port.req_a + 1'b1) : port.req_a;
  assign mag_b  = sign_b ? (~port.req_b + 1'b1) : port.req_b;

  // bring in the next dividend bit, then try to take the divisor away
  assign shifted  = rq << 1;
  assign diff     = {1'b0, shifted[2*`IMULDIV_XLEN-1:`IMULDIV_XLEN]} - {1'b0, dvs};
  assign trial_ok = ~diff[`IMULDIV_XLEN];

  // quotient sign from both operands, remainder follows the dividend
  assign rem_fix = r_neg ? (~rq[2*`IMULDIV_XLEN-1:`IMULDIV_XLEN] + 1'b1)
                         : rq[2*`IMULDIV_XLEN-1:`IMULDIV_XLEN];
  // divide by zero forces all ones, the remainder is already the dividend
  assign quot_fix = dbz   ? {`IMULDIV_XLEN{1'b1}}
                  : q_neg ? (~rq[`IMULDIV_XLEN-1:0] + 1'b1)
                  : rq[`IMULDIV_XLEN-1:0];

  always_ff @(posedge clk) begin
    if (load_en) begin
      rq    <= {{`IMULDIV_XLEN{1'b0}}, mag_a};
      dvs   <= mag_b;
      q_neg <= sign_a ^ sign_b;
      r_neg <= sign_a;
      dbz   <= (port.req_b == '0);
    end else if (step_en) begin
      // keep the difference and set the quotient bit, else restore
      if (trial_ok) begin
        rq <= {diff[`IMULDIV_XLEN-1:0], shifted[`IMULDIV_XLEN-1:1], 1'b1};
      end else begin
        rq <= shifted;
      end
    end else if (sign_en) begin
      rq <= {rem_fix, quot_fix};
    end
  end

  assign result.div       = rq;
  assign port.resp_result = result;

endmodule

`default_nettype wire

// ==== rtl/imuldiv_iterative.sv ====
/*
 * iterative signed multiply/divide unit, top level with plain val/rdy ports;
 * one multiply and one divide may be in flight, responses tagged by function
 */

`timescale 1ns/1ps
`default_nettype none

`include "imuldiv_settings.svh"

module imuldiv_iterative import imuldiv_pkg::*; (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     req_val,
  input  muldiv_fn_e               req_fn,
  input  logic [`IMULDIV_XLEN-1:0] req_a,
  input  logic [`IMULDIV_XLEN-1:0] req_b,
  output logic                     req_rdy,
  output logic                     resp_val,
  input  logic                     resp_rdy,
  output muldiv_fn_e               resp_fn,
  output muldiv_result_u           resp_result
);

  // one link per arithmetic unit
  imuldiv_unit_if mul_if ();
  imuldiv_unit_if div_if ();

  imuldiv_port_arbiter i_port_arbiter (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_rdy     (req_rdy),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_fn     (resp_fn),
    .resp_result (resp_result),
    .mul         (mul_if.arb),
    .div         (div_if.arb)
  );

  imuldiv_mul_iterative i_mul_iterative (
    .clk   (clk),
    .reset (reset),
    .port  (mul_if.unit)
  );

  imuldiv_div_iterative i_div_iterative (
    .clk   (clk),
    .reset (reset),
    .port  (div_if.unit)
  );

endmodule

`default_nettype wire

// ==== rtl/imuldiv_mul_iterative.sv ====
/*
 * iterative signed shift-and-add multiplier, one bit of b per cycle;
 * takes one request at a time and holds the 64-bit product until taken
 */

`timescale 1ns/1ps
`default_nettype none

`include "imuldiv_settings.svh"

module imuldiv_mul_iterative import imuldiv_pkg::*; (
  input logic          clk,
  input logic          reset,
  imuldiv_unit_if.unit port
);

  localparam int cnt_w = $clog2(`IMULDIV_STEPS + 1);

  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_calc = 2'd1;
  localparam logic [1:0] st_done = 2'd2;

  // --------------------------------------------------------------------------
  // control
  // --------------------------------------------------------------------------

  logic [1:0]       state;
  logic [cnt_w-1:0] count;
  logic             load_en;
  logic             step_en;
  logic             sign_en;

  // load on accept, then STEPS shift/add cycles, then one cycle for the sign
  assign load_en = (state == st_idle) && port.req_val;
  assign step_en = (state == st_calc) && (count != cnt_w'(`IMULDIV_STEPS));
  assign sign_en = (state == st_calc) && (count == cnt_w'(`IMULDIV_STEPS));

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      count <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (load_en) begin
            state <= st_calc;
            count <= '0;
          end
        end
        st_calc: begin
          if (sign_en) begin
            state <= st_done;
          end else begin
            count <= count + 1'b1;
          end
        end
        st_done: begin
          // stay busy until the arbiter takes the product
          if (port.resp_rdy) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  assign port.req_rdy  = (state == st_idle);
  assign port.resp_val = (state == st_done);

  // --------------------------------------------------------------------------
  // datapath
  // --------------------------------------------------------------------------

  logic                       sign_a;
  logic                       sign_b;
  logic [`IMULDIV_XLEN-1:0]   mag_a;
  logic [`IMULDIV_XLEN-1:0]   mag_b;
  logic [2*`IMULDIV_XLEN-1:0] a_reg;
  logic [`IMULDIV_XLEN-1:0]   b_reg;
  logic [2*`IMULDIV_XLEN-1:0] acc;
  logic [2*`IMULDIV_XLEN-1:0] acc_next;
  logic                       neg;
  muldiv_result_u             result;

  // operand magnitudes, the most negative value maps to 2**31 unsigned
  assign sign_a = port.req_a[`IMULDIV_XLEN-1];
  assign sign_b = port.req_b[`IMULDIV_XLEN-1];
  assign mag_a  = sign_a ? (~port.req_a + 1'b1) : port.req_a;
  assign mag_b  = sign_b ? (~port.req_b + 1'b1) : port.req_b;

  // add the shifted multiplicand when the current multiplier bit is set
  assign acc_next = b_reg[0] ? (acc + a_reg) : acc;

  always_ff @(posedge clk) begin
    if (load_en) begin
      a_reg <= {{`IMULDIV_XLEN{1'b0}}, mag_a};
      b_reg <= mag_b;
      acc   <= '0;
      neg   <= sign_a ^ sign_b;
    end else if (step_en) begin
      acc   <= acc_next;
      a_reg <= a_reg << 1;
      b_reg <= b_reg >> 1;
    end else if (sign_en) begin
      // negate the magnitude product when exactly one operand was negative
      acc <= neg ? (~acc + 1'b1) : acc;
    end
  end

  assign result.product   = acc;
  assign port.resp_result = result;

endmodule

`default_nettype wire

// ==== rtl/imuldiv_pkg.sv ====
/*
 * types shared by the multiply/divide RTL and its testbench:
 * the function select and the two views of the 64-bit result word
 */

`default_nettype none

`include "imuldiv_settings.svh"

package imuldiv_pkg;

  // function select, also tags each response
  typedef enum logic {
    fn_mul = 1'b0,
    fn_div = 1'b1
  } muldiv_fn_e;

  // divide result, remainder in the upper half
  typedef struct packed {
    logic [`IMULDIV_XLEN-1:0] rem;
    logic [`IMULDIV_XLEN-1:0] quot;
  } muldiv_div_t;

  // one response word, read as a product or as quotient and remainder
  typedef union packed {
    logic signed [2*`IMULDIV_XLEN-1:0] product;
    muldiv_div_t                       div;
  } muldiv_result_u;

endpackage

`default_nettype wire

// ==== rtl/imuldiv_port_arbiter.sv ====
/*
 * shares one request port and one response port between the multiplier
 * and the divider; requests go by function, responses by round-robin
 */

`timescale 1ns/1ps
`default_nettype none

`include "imuldiv_settings.svh"

module imuldiv_port_arbiter import imuldiv_pkg::*; (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     req_val,
  input  muldiv_fn_e               req_fn,
  input  logic [`IMULDIV_XLEN-1:0] req_a,
  input  logic [`IMULDIV_XLEN-1:0] req_b,
  output logic                     req_rdy,
  output logic                     resp_val,
  input  logic                     resp_rdy,
  output muldiv_fn_e               resp_fn,
  output muldiv_result_u           resp_result,
  imuldiv_unit_if.arb              mul,
  imuldiv_unit_if.arb              div
);

  // --------------------------------------------------------------------------
  // request steering
  // --------------------------------------------------------------------------

  // operands go to both units, only the selected one sees val
  assign mul.req_val = req_val && (req_fn == fn_mul);
  assign div.req_val = req_val && (req_fn == fn_div);
  assign mul.req_a   = req_a;
  assign mul.req_b   = req_b;
  assign div.req_a   = req_a;
  assign div.req_b   = req_b;
  assign req_rdy     = (req_fn == fn_mul) ? mul.req_rdy : div.req_rdy;

  // --------------------------------------------------------------------------
  // response arbitration
  // --------------------------------------------------------------------------

  muldiv_fn_e ptr;
  muldiv_fn_e held;
  muldiv_fn_e grant;
  logic       stalled;

  always_comb begin
    if (stalled) begin
      // a presented response keeps its grant until it transfers
      grant = held;
    end else if (mul.resp_val && div.resp_val) begin
      grant = ptr;
    end else if (div.resp_val) begin
      grant = fn_div;
    end else begin
      grant = fn_mul;
    end
  end

  assign resp_val    = mul.resp_val || div.resp_val;
  assign resp_fn     = grant;
  assign resp_result = (grant == fn_div) ? div.resp_result : mul.resp_result;
  assign mul.resp_rdy = resp_rdy && (grant == fn_mul);
  assign div.resp_rdy = resp_rdy && (grant == fn_div);

  always_ff @(posedge clk) begin
    if (reset) begin
      ptr     <= fn_mul;
      held    <= fn_mul;
      stalled <= 1'b0;
    end else begin
      stalled <= resp_val && !resp_rdy;
      held    <= grant;
      // the other unit wins the next tie
      if (resp_val && resp_rdy) begin
        ptr <= (grant == fn_mul) ? fn_div : fn_mul;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/imuldiv_settings.svh ====
/*
 * operand width and iteration count for the iterative multiply/divide unit,
 * included by the package, the interface, the RTL and the testbench
 */

`ifndef IMULDIV_SETTINGS_SVH
`define IMULDIV_SETTINGS_SVH

// operand width in bits, both units work on signed words of this size
`define IMULDIV_XLEN 32

// one iteration per operand bit for shift-and-add and restoring division
`define IMULDIV_STEPS `IMULDIV_XLEN

`endif

// ==== rtl/imuldiv_unit_if.sv ====
/*
 * val/rdy request and response link between the port arbiter and one
 * arithmetic unit, one instance per unit
 */

`timescale 1ns/1ps
`default_nettype none

`include "imuldiv_settings.svh"

interface imuldiv_unit_if import imuldiv_pkg::*; ();

  // request channel, operands are signed words
  logic                     req_val;
  logic                     req_rdy;
  logic [`IMULDIV_XLEN-1:0] req_a;
  logic [`IMULDIV_XLEN-1:0] req_b;

  // response channel, held by the unit until it transfers
  logic                     resp_val;
  logic                     resp_rdy;
  muldiv_result_u           resp_result;

  modport arb (
    output req_val, req_a, req_b, resp_rdy,
    input  req_rdy, resp_val, resp_result
  );

  modport unit (
    input  req_val, req_a, req_b, resp_rdy,
    output req_rdy, resp_val, resp_result
  );

endinterface

`default_nettype wire

// ==== tb.f ====
+incdir+rtl
rtl/imuldiv_pkg.sv
rtl/imuldiv_unit_if.sv
rtl/imuldiv_mul_iterative.sv
rtl/imuldiv_div_iterative.sv
rtl/imuldiv_port_arbiter.sv
rtl/imuldiv_iterative.sv
verification/imuldiv_assertions.sv
verification/imuldiv_tb.sv

// ==== verification/imuldiv_assertions.sv ====
/*
 * concurrent checks on the shared response port, bound into the port arbiter;
 * failures are also counted so the testbench can see them at the end
 */

`timescale 1ns/1ps
`default_nettype none

`include "imuldiv_settings.svh"

module imuldiv_assertions import imuldiv_pkg::*; (
  input logic           clk,
  input logic           reset,
  input logic           resp_val,
  input logic           resp_rdy,
  input muldiv_fn_e     resp_fn,
  input muldiv_result_u resp_result
);

  int fail_count;

  initial fail_count = 0;

  // a stalled response keeps its tag and value until it is taken
  stall_stable: assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val && $stable(resp_fn) && $stable(resp_result))
    else begin
      $error("stalled response changed before it was taken");
      fail_count = fail_count + 1;
    end

  // both units come out of reset idle
  reset_idle: assert property (@(posedge clk) reset |=> !resp_val)
    else begin
      $error("resp_val high in the cycle after reset");
      fail_count = fail_count + 1;
    end

endmodule

bind imuldiv_port_arbiter imuldiv_assertions i_assertions (
  .clk         (clk),
  .reset       (reset),
  .resp_val    (resp_val),
  .resp_rdy    (resp_rdy),
  .resp_fn     (resp_fn),
  .resp_result (resp_result)
);

`default_nettype wire

// ==== verification/imuldiv_tb.sv ====
/*
 * directed and seeded random requests to the iterative multiply/divide unit,
 * with every response checked against a behavioural model of the arithmetic
 */

`timescale 1ns/1ps
`default_nettype none

`include "imuldiv_settings.svh"

module imuldiv_tb import imuldiv_pkg::*; ();

  typedef logic [2*`IMULDIV_XLEN-1:0] word_t;
  typedef logic [`IMULDIV_XLEN-1:0]   operand_t;

  localparam int num_random   = 160;
  // latency 2, corners 8, back to back 2, stall 2
  localparam int num_directed = 14;
  localparam int timeout_cycles = (num_random + num_directed) * (`IMULDIV_STEPS + 2) * 3;
  localparam operand_t most_neg = {1'b1, {(`IMULDIV_XLEN-1){1'b0}}};

  logic           clk;
  logic           reset;
  logic           req_val;
  muldiv_fn_e     req_fn;
  operand_t       req_a;
  operand_t       req_b;
  logic           req_rdy;
  logic           resp_val;
  logic           resp_rdy;
  muldiv_fn_e     resp_fn;
  muldiv_result_u resp_result;

  // model state with one slot per function
  bit             busy [2];
  muldiv_result_u expected [2];
  int             req_edge [2];
  int             cycle_count;
  bit             req_taken;

  imuldiv_iterative i_imuldiv_iterative (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_rdy     (req_rdy),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_fn     (resp_fn),
    .resp_result (resp_result)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // edge counter that also times the latency check
  initial begin
    cycle_count = 0;
    forever begin
      @(posedge clk);
      cycle_count = cycle_count + 1;
      if (cycle_count > timeout_cycles) begin
        $display("timeout: run did not finish within %0d cycles", timeout_cycles);
        fail_run();
      end
    end
  end

  // --------------------------------------------------------------------------
  // model and checks
  // --------------------------------------------------------------------------

  task automatic fail_run();
    $display("TESTS FAILED");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic check(string name, word_t actual, word_t exp_value);
    if (actual !== exp_value) begin
      $display("** Error at time %0t: %s is %h, expected %h", $time, name, actual, exp_value);
      fail_run();
    end
  endtask

  // exact signed product; quotient truncates toward zero, remainder follows the dividend
  function automatic muldiv_result_u model_result(muldiv_fn_e fn, operand_t a, operand_t b);
    muldiv_result_u r;
    longint         sa;
    longint         sb;
    longint         q;
    longint         m;
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    if (fn == fn_mul) begin
      r.product = sa * sb;
    end else if (b == '0) begin
      r.div.quot = '1;
      r.div.rem  = a;
    end else begin
      // most negative over -1 wraps back to itself in the low word
      q          = sa / sb;
      m          = sa % sb;
      r.div.quot = q[`IMULDIV_XLEN-1:0];
      r.div.rem  = m[`IMULDIV_XLEN-1:0];
    end
    return r;
  endfunction

  // extremes show up often next to plain random words
  function automatic operand_t pick_operand();
    case ($urandom_range(7))
      0: return '0;
      1: return '1;
      2: return most_neg;
      3: return operand_t'(1);
      default: return $urandom();
    endcase
  endfunction

  // --------------------------------------------------------------------------
  // stimulus
  // --------------------------------------------------------------------------

  // drive on the falling edge, then look at both handshakes once settled
  task automatic run_cycle(logic val, muldiv_fn_e fn, operand_t a, operand_t b, logic rdy);
    int f;
    @(negedge clk);
    req_val  = val;
    req_fn   = fn;
    req_a    = a;
    req_b    = b;
    resp_rdy = rdy;
    #1;
    // a busy unit refuses its own function
    f = int'(req_fn);
    check("req_rdy", word_t'(req_rdy), word_t'(!busy[f]));
    req_taken = req_val && req_rdy;
    if (resp_val && resp_rdy) begin
      f = int'(resp_fn);
      if (!busy[f]) begin
        $display("response tagged with function %0d but none is outstanding", f);
        fail_run();
      end
      if (resp_fn == fn_mul) begin
        check("resp_result.product", word_t'(resp_result.product),
              word_t'(expected[f].product));
      end else begin
        check("resp_result.div.quot", word_t'(resp_result.div.quot),
              word_t'(expected[f].div.quot));
        check("resp_result.div.rem", word_t'(resp_result.div.rem),
              word_t'(expected[f].div.rem));
      end
      busy[f] = 1'b0;
    end
    if (req_taken) begin
      f           = int'(req_fn);
      expected[f] = model_result(req_fn, req_a, req_b);
      busy[f]     = 1'b1;
      req_edge[f] = cycle_count + 1;
    end
  endtask

  // val and operands stay put until the request is taken
  task automatic issue(muldiv_fn_e fn, operand_t a, operand_t b, logic rdy);
    req_taken = 1'b0;
    while (!req_taken) begin
      run_cycle(1'b1, fn, a, b, rdy);
    end
  endtask

  task automatic drain();
    while (busy[0] || busy[1]) begin
      run_cycle(1'b0, fn_mul, '0, '0, 1'b1);
    end
  endtask

  task automatic latency_test(muldiv_fn_e fn);
    int f;
    f = int'(fn);
    issue(fn, pick_operand(), pick_operand(), 1'b0);
    while (!resp_val) begin
      run_cycle(1'b0, fn, '0, '0, 1'b0);
    end
    check("resp_val latency", word_t'(cycle_count - req_edge[f]),
          word_t'(`IMULDIV_STEPS + 1));
    drain();
  endtask

  task automatic corner_cases();
    issue(fn_mul, most_neg, most_neg, 1'b1);
    issue(fn_div, most_neg, '1, 1'b1);
    drain();
    issue(fn_mul, most_neg, '1, 1'b1);
    issue(fn_div, operand_t'(12345), '0, 1'b1);
    drain();
    issue(fn_mul, '1, '1, 1'b1);
    issue(fn_div, operand_t'(-7), operand_t'(2), 1'b1);
    drain();
    issue(fn_mul, '0, most_neg, 1'b1);
    issue(fn_div, operand_t'(7), operand_t'(-2), 1'b1);
    drain();
  endtask

  // divide result held under back-pressure while the multiplier still takes work
  task automatic stall_test();
    muldiv_result_u held;
    issue(fn_div, pick_operand(), pick_operand(), 1'b0);
    while (!resp_val) begin
      run_cycle(1'b0, fn_div, '0, '0, 1'b0);
    end
    held = resp_result;
    issue(fn_mul, pick_operand(), pick_operand(), 1'b0);
    // long enough for the multiply to finish and tie with the held divide
    repeat (`IMULDIV_STEPS + 4) begin
      run_cycle(1'b0, fn_div, '0, '0, 1'b0);
      check("resp_val", word_t'(resp_val), word_t'(1'b1));
      check("resp_fn", word_t'(resp_fn), word_t'(fn_div));
      check("resp_result", word_t'(resp_result), word_t'(held));
    end
    drain();
  endtask

  task automatic random_phase();
    int         issued;
    logic       val;
    muldiv_fn_e fn;
    operand_t   a;
    operand_t   b;
    issued = 0;
    val    = 1'b0;
    fn     = fn_mul;
    a      = '0;
    b      = '0;
    while (issued < num_random || busy[0] || busy[1]) begin
      if (!val && issued < num_random && $urandom_range(3) != 0) begin
        val = 1'b1;
        fn  = ($urandom_range(1) == 0) ? fn_mul : fn_div;
        a   = pick_operand();
        b   = pick_operand();
      end
      // resp_rdy withheld about a quarter of the time
      run_cycle(val, fn, a, b, $urandom_range(3) != 0);
      if (req_taken) begin
        val    = 1'b0;
        issued = issued + 1;
      end
    end
  endtask

  initial begin
    void'($urandom(32'hcd60_bb91));
    reset      = 1'b1;
    req_val    = 1'b0;
    req_fn     = fn_mul;
    req_a      = '0;
    req_b      = '0;
    resp_rdy   = 1'b0;
    busy[0]    = 1'b0;
    busy[1]    = 1'b0;
    req_taken  = 1'b0;
    repeat (3) @(negedge clk);
    reset = 1'b0;
    // idle straight out of reset
    run_cycle(1'b0, fn_mul, '0, '0, 1'b0);
    check("resp_val", word_t'(resp_val), '0);
    latency_test(fn_mul);
    latency_test(fn_div);
    corner_cases();
    issue(fn_mul, pick_operand(), pick_operand(), 1'b1);
    issue(fn_div, pick_operand(), pick_operand(), 1'b1);
    drain();
    stall_test();
    random_phase();
    if (i_imuldiv_iterative.i_port_arbiter.i_assertions.fail_count != 0) begin
      $display("a bound assertion failed during the run");
      fail_run();
    end else begin
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire
